// File: design/complexFirPkg.sv
package complexFirPkg;

	// Width of one real or imaginary component of a sample or a coefficient.
	localparam int dataWidth = 8;

	// Largest filter the design supports. The tapCount parameter must stay at or below it.
	localparam int maxTaps = 16;

	// Bits needed to address any tap of the largest filter.
	localparam int tapIndexWidth = $clog2(maxTaps);

	// A full-scale product needs two data widths.
	// Summing maxTaps products adds log2(maxTaps) bits, and the complex subtraction one more.
	localparam int accumWidth = 2 * dataWidth + tapIndexWidth + 1;

	// One component of an input sample.
	typedef logic signed [dataWidth-1:0] sample_t;

	// One component of a filter coefficient.
	typedef logic signed [dataWidth-1:0] coef_t;

	// One component of a filter result.
	typedef logic signed [accumWidth-1:0] accum_t;

	// Position of a coefficient in the bank or in the core's coefficient register.
	typedef logic [tapIndexWidth-1:0] tapIndex_t;

	// Complex input sample, real part in the upper half.
	typedef struct packed {
		sample_t re;
		sample_t im;
	} complexSample_t;

	// Complex coefficient, laid out like a sample.
	typedef struct packed {
		coef_t re;
		coef_t im;
	} complexCoef_t;

	// Complex filter output at full accumulator precision.
	typedef struct packed {
		accum_t re;
		accum_t im;
	} complexResult_t;

	// Filter core states.
	typedef enum logic [1:0] {
		stIdle,
		stLoading,
		stFiltering,
		stStopping
	} firState_t;

endpackage

// File: design/coefficientBank.sv
`timescale 1ns/100ps

module coefficientBank #(
	parameter int tapCount = 12
) (
	input  logic                        clock,
	input  logic                        rstN,
	input  logic                        coefWrite,
	input  complexFirPkg::tapIndex_t    coefIndex,
	input  complexFirPkg::complexCoef_t coefData,
	input  logic                        loadCoefficients,
	input  logic                        loadDone,
	input  logic                        filterActive,
	output complexFirPkg::complexCoef_t coefStream,
	output logic                        coefShift,
	output logic                        coefLast
);

	import complexFirPkg::*;

	// Index of the final entry, the one that is sent together with coefLast.
	localparam tapIndex_t lastIndex = tapIndex_t'(tapCount - 1);

	complexCoef_t bank [tapCount];
	tapIndex_t readIndex;
	logic awaitingDone;
	logic startStream;

	// A load pulse only starts a stream when the bank is quiet and the core is not filtering.
	// While a stream is running, or until the core confirms it with loadDone, pulses are dropped.
	assign startStream = loadCoefficients && !coefShift && !awaitingDone && !filterActive;

	// Host writes land at any time.
	// An index past the configured tap count has no entry and is dropped.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int i = 0; i < tapCount; i++) begin
				bank[i] <= '0;
			end
		end else if (coefWrite && (int'(coefIndex) < tapCount)) begin
			bank[coefIndex] <= coefData;
		end
	end

	// Read sequencer.
	// The first entry is registered on the edge that samples the load pulse.
	// Each later edge presents the next entry, so coefShift stays high for tapCount cycles.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			readIndex <= '0;
			coefStream <= '0;
			coefShift <= 1'b0;
			coefLast <= 1'b0;
			awaitingDone <= 1'b0;
		end else begin
			if (coefShift) begin
				if (coefLast) begin
					// The final entry has been taken, so the stream ends here.
					coefShift <= 1'b0;
					coefLast <= 1'b0;
					awaitingDone <= 1'b1;
				end else begin
					coefStream <= bank[readIndex];
					coefLast <= (readIndex == lastIndex);
					if (readIndex != lastIndex) begin
						readIndex <= readIndex + tapIndex_t'(1);
					end
				end
			end else if (startStream) begin
				// Entry 0 goes first and ends up at tap 0 in the core.
				coefStream <= bank[0];
				coefShift <= 1'b1;
				coefLast <= 1'b0;
				readIndex <= tapIndex_t'(1);
			end

			// The core has switched to filtering. The bank may accept a pulse again after a stop.
			if (loadDone) begin
				awaitingDone <= 1'b0;
			end
		end
	end

endmodule

// File: design/complexFirCore.sv
`timescale 1ns/100ps

module complexFirCore #(
	parameter int tapCount = 12
) (
	input  logic                          clock,
	input  logic                          rstN,
	input  complexFirPkg::complexCoef_t   coefStream,
	input  logic                          coefShift,
	input  logic                          coefLast,
	input  logic                          sampleValid,
	input  complexFirPkg::complexSample_t sampleIn,
	input  logic                          stopFilter,
	output logic                          loadDone,
	output logic                          filterActive,
	output complexFirPkg::complexResult_t result,
	output logic                          resultValid
);

	import complexFirPkg::*;

	firState_t state;

	// Coefficient k sits at coefReg[k] once loading is complete.
	complexCoef_t coefReg [tapCount];

	// history[0] is the sample that arrived one strobe ago. The new sample itself
	// is not stored before it is used, so one entry fewer than the tap count is enough.
	complexSample_t history [tapCount - 1];

	// Sample seen by each tap in the current cycle, the incoming one at tap 0.
	complexSample_t tapSample [tapCount];

	logic coefAccept;
	logic sampleAccept;
	accum_t sumReRe;
	accum_t sumImIm;
	accum_t sumReIm;
	accum_t sumImRe;
	complexResult_t nextResult;

	// Signed product of one sample component and one coefficient component,
	// widened before the multiply so no bits are lost.
	function automatic accum_t multiplyTerm(input sample_t sample, input coef_t coef);
		accum_t wideSample;
		accum_t wideCoef;
		wideSample = accum_t'(sample);
		wideCoef = accum_t'(coef);
		return wideSample * wideCoef;
	endfunction

	// Coefficients are taken only before filtering starts. Samples are taken only while filtering.
	assign coefAccept = coefShift && ((state == stIdle) || (state == stLoading));
	assign sampleAccept = sampleValid && (state == stFiltering);
	assign filterActive = (state == stFiltering);

	// Control FSM.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= stIdle;
			loadDone <= 1'b0;
		end else begin
			loadDone <= 1'b0;
			case (state)
				stIdle: begin
					// The first coefficient of a stream is shifted in on this same edge.
					if (coefShift) begin
						state <= stLoading;
					end
				end
				stLoading: begin
					if (coefShift && coefLast) begin
						state <= stFiltering;
						loadDone <= 1'b1;
					end
				end
				stFiltering: begin
					if (stopFilter) begin
						state <= stStopping;
					end
				end
				stStopping: begin
					// History is cleared during this cycle.
					state <= stIdle;
				end
			endcase
		end
	end

	// Coefficient shift register.
	// New values enter at the top and move down, so the entry streamed first ends at tap 0.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int i = 0; i < tapCount; i++) begin
				coefReg[i] <= '0;
			end
		end else if (coefAccept) begin
			for (int i = 0; i < tapCount - 1; i++) begin
				coefReg[i] <= coefReg[i + 1];
			end
			coefReg[tapCount - 1] <= coefStream;
		end
	end

	// Sample history. A stop wipes it so the next run starts from zero.
	always_ff @(posedge clock) begin
		if (!rstN || (state == stStopping)) begin
			for (int i = 0; i < tapCount - 1; i++) begin
				history[i] <= '0;
			end
		end else if (sampleAccept) begin
			history[0] <= sampleIn;
			for (int i = 1; i < tapCount - 1; i++) begin
				history[i] <= history[i - 1];
			end
		end
	end

	// Tap k sees the sample from k strobes ago, the incoming one at tap 0.
	always_comb begin
		tapSample[0] = sampleIn;
		for (int k = 1; k < tapCount; k++) begin
			tapSample[k] = history[k - 1];
		end
	end

	// Four real dot products, combined as (a + jb)(c + jd) = (ac - bd) + j(ad + bc).
	always_comb begin
		sumReRe = '0;
		sumImIm = '0;
		sumReIm = '0;
		sumImRe = '0;
		for (int k = 0; k < tapCount; k++) begin
			sumReRe = sumReRe + multiplyTerm(tapSample[k].re, coefReg[k].re);
			sumImIm = sumImIm + multiplyTerm(tapSample[k].im, coefReg[k].im);
			sumReIm = sumReIm + multiplyTerm(tapSample[k].re, coefReg[k].im);
			sumImRe = sumImRe + multiplyTerm(tapSample[k].im, coefReg[k].re);
		end
		nextResult.re = sumReRe - sumImIm;
		nextResult.im = sumReIm + sumImRe;
	end

	// Output register. One result per accepted sample, valid for a single cycle.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			result <= '0;
			resultValid <= 1'b0;
		end else begin
			resultValid <= sampleAccept;
			if (sampleAccept) begin
				result <= nextResult;
			end
		end
	end

endmodule

// File: design/complexFirTop.sv
`timescale 1ns/100ps

module complexFirTop #(
	parameter int tapCount = 12
) (
	input  logic                          clock,
	input  logic                          rstN,
	input  logic                          coefWrite,
	input  complexFirPkg::tapIndex_t      coefIndex,
	input  complexFirPkg::complexCoef_t   coefData,
	input  logic                          loadCoefficients,
	input  logic                          sampleValid,
	input  complexFirPkg::complexSample_t sampleIn,
	input  logic                          stopFilter,
	output complexFirPkg::complexResult_t result,
	output logic                          resultValid,
	output logic                          filterActive
);

	import complexFirPkg::*;

	// Coefficient stream from the bank into the core.
	complexCoef_t coefStream;
	logic coefShift;
	logic coefLast;

	// Core confirms the last coefficient with this.
	logic loadDone;

	// The bank also watches filterActive so that it never streams into a running filter.
	coefficientBank #(
		.tapCount(tapCount)
	) bank (
		.clock(clock),
		.rstN(rstN),
		.coefWrite(coefWrite),
		.coefIndex(coefIndex),
		.coefData(coefData),
		.loadCoefficients(loadCoefficients),
		.loadDone(loadDone),
		.filterActive(filterActive),
		.coefStream(coefStream),
		.coefShift(coefShift),
		.coefLast(coefLast)
	);

	complexFirCore #(
		.tapCount(tapCount)
	) core (
		.clock(clock),
		.rstN(rstN),
		.coefStream(coefStream),
		.coefShift(coefShift),
		.coefLast(coefLast),
		.sampleValid(sampleValid),
		.sampleIn(sampleIn),
		.stopFilter(stopFilter),
		.loadDone(loadDone),
		.filterActive(filterActive),
		.result(result),
		.resultValid(resultValid)
	);

endmodule

// File: tb/firChecker.sv
`timescale 1ns/100ps

module firChecker #(
	parameter int tapCount = 12
) (
	input  logic                          clock,
	input  logic                          rstN,
	input  logic                          coefWrite,
	input  complexFirPkg::tapIndex_t      coefIndex,
	input  complexFirPkg::complexCoef_t   coefData,
	input  logic                          loadCoefficients,
	input  logic                          sampleValid,
	input  complexFirPkg::complexSample_t sampleIn,
	input  logic                          stopFilter,
	input  complexFirPkg::complexResult_t result,
	input  logic                          resultValid,
	input  logic                          filterActive,
	output int                            errorCount,
	output int                            mismatchCount
);

	import complexFirPkg::*;

	// Copy of what the host has written into the bank.
	complexCoef_t bankMirror [tapCount];

	// Coefficients in use, taken from the mirror when filtering starts.
	complexCoef_t activeCoef [tapCount];

	// history[0] is the newest accepted sample.
	complexSample_t history [tapCount];

	logic pending;
	logic wasActive;
	int expectRe;
	int expectIm;

	// Expected filterActive level, and the cycles left until a running load completes.
	logic expectActive;
	int loadCountdown;

	task automatic clearHistory();
		for (int k = 0; k < tapCount; k++) begin
			history[k] = '0;
		end
	endtask

	// Shifts the new sample in and forms the expected complex sum.
	// Real part is re*re minus im*im, imaginary part is re*im plus im*re.
	task automatic predict();
		for (int k = tapCount - 1; k > 0; k--) begin
			history[k] = history[k - 1];
		end
		history[0] = sampleIn;
		expectRe = 0;
		expectIm = 0;
		for (int k = 0; k < tapCount; k++) begin
			expectRe += int'(history[k].re) * int'(activeCoef[k].re)
				- int'(history[k].im) * int'(activeCoef[k].im);
			expectIm += int'(history[k].re) * int'(activeCoef[k].im)
				+ int'(history[k].im) * int'(activeCoef[k].re);
		end
	endtask

	task automatic compareResult();
		accum_t wantRe;
		accum_t wantIm;
		wantRe = accum_t'(expectRe);
		wantIm = accum_t'(expectIm);
		if ((result.re !== wantRe) || (result.im !== wantIm)) begin
			mismatchCount++;
			$display("MISMATCH at time %0t: expected (%0d, %0d), got (%0d, %0d)",
				$time, wantRe, wantIm, result.re, result.im);
		end
	endtask

	// Everything is sampled on the falling edge, half a cycle away from any change.
	always @(negedge clock) begin
		if (!rstN) begin
			for (int k = 0; k < tapCount; k++) begin
				bankMirror[k] = '0;
				activeCoef[k] = '0;
			end
			clearHistory();
			pending = 1'b0;
			wasActive = 1'b0;
			expectActive = 1'b0;
			loadCountdown = 0;
			errorCount = 0;
			mismatchCount = 0;
		end else begin
			// The stream takes tapCount cycles, and filtering starts on the cycle after it.
			if (loadCountdown > 0) begin
				loadCountdown--;
				if (loadCountdown == 0) begin
					expectActive = 1'b1;
				end
			end
			if (filterActive !== expectActive) begin
				mismatchCount++;
				$display("MISMATCH at time %0t: filterActive expected %0b, got %0b",
					$time, expectActive, filterActive);
			end
			// The sample accepted one cycle ago must show up now, and nothing else may.
			if (pending && !resultValid) begin
				errorCount++;
				$display("ERROR at time %0t: no result in the cycle after an accepted sample",
					$time);
			end else if (!pending && resultValid) begin
				errorCount++;
				$display("ERROR at time %0t: result strobe without a sample the cycle before",
					$time);
			end else if (pending) begin
				compareResult();
			end
			// Filtering starts with the bank contents and ends with an empty history.
			if (filterActive && !wasActive) begin
				for (int k = 0; k < tapCount; k++) begin
					activeCoef[k] = bankMirror[k];
				end
			end else if (!filterActive && wasActive) begin
				clearHistory();
			end
			wasActive = filterActive;
			if (coefWrite && (int'(coefIndex) < tapCount)) begin
				bankMirror[coefIndex] = coefData;
			end
			pending = sampleValid && filterActive;
			if (pending) begin
				predict();
			end
			// A stop ends filtering at the next edge.
			// A load pulse only counts while the filter is neither running nor loading.
			if (expectActive) begin
				if (stopFilter) begin
					expectActive = 1'b0;
				end
			end else if ((loadCountdown == 0) && loadCoefficients) begin
				loadCountdown = tapCount + 1;
			end
		end
	end

endmodule

// File: tb/complexFir_asserts.sv
`timescale 1ns/100ps

module complexFirAsserts (
	input logic clock,
	input logic rstN,
	input logic sampleValid,
	input logic filterActive,
	input logic resultValid,
	input logic coefShift
);

	// An accepted sample gives a result strobe on the next cycle.
	property resultFollowsSample;
		@(posedge clock) disable iff (!rstN)
			(sampleValid && filterActive) |=> resultValid;
	endproperty

	// A result strobe needs an accepted sample one cycle earlier.
	property resultNeedsSample;
		@(posedge clock) disable iff (!rstN)
			resultValid |-> $past(sampleValid && filterActive);
	endproperty

	// The bank never streams into a running filter.
	property noStreamWhileFiltering;
		@(posedge clock) disable iff (!rstN)
			coefShift |-> !filterActive;
	endproperty

	// After a reset edge the control outputs are quiet.
	property quietAfterReset;
		@(posedge clock)
			!rstN |=> (!resultValid && !filterActive && !coefShift);
	endproperty

	assert property (resultFollowsSample)
		else $error("Accepted sample was not followed by a result strobe");
	assert property (resultNeedsSample)
		else $error("Result strobe without an accepted sample");
	assert property (noStreamWhileFiltering)
		else $error("Coefficient stream active while filtering");
	assert property (quietAfterReset)
		else $error("Control output active during reset");

endmodule

bind complexFirTop complexFirAsserts protocolAsserts (
	.clock(clock),
	.rstN(rstN),
	.sampleValid(sampleValid),
	.filterActive(filterActive),
	.resultValid(resultValid),
	.coefShift(coefShift)
);

// File: tb/complexFirTb.sv
`timescale 1ns/100ps

module complexFirTb;

	import complexFirPkg::*;

	localparam int tapCount = 12;

	// Longest time any wait on filterActive may take, in clock cycles.
	localparam int waitLimit = 50;

	// Operations that a stimulus row can carry.
	typedef enum logic [2:0] {
		opWrite,
		opLoad,
		opSample,
		opIdle,
		opStop,
		opWaitActive
	} stepOp_t;

	// One row of the stimulus table.
	// For opWaitActive, bit 0 of value is the filterActive level that is expected.
	typedef struct packed {
		stepOp_t op;
		tapIndex_t index;
		logic [15:0] value;
	} step_t;

	logic clock;
	logic rstN;
	logic coefWrite;
	tapIndex_t coefIndex;
	complexCoef_t coefData;
	logic loadCoefficients;
	logic sampleValid;
	complexSample_t sampleIn;
	logic stopFilter;
	complexResult_t result;
	logic resultValid;
	logic filterActive;

	int seed;
	int timeoutCount;
	int checkerErrors;
	int mismatchCount;
	step_t stimulus [$];

	complexFirTop #(
		.tapCount(tapCount)
	) dut (
		.clock(clock),
		.rstN(rstN),
		.coefWrite(coefWrite),
		.coefIndex(coefIndex),
		.coefData(coefData),
		.loadCoefficients(loadCoefficients),
		.sampleValid(sampleValid),
		.sampleIn(sampleIn),
		.stopFilter(stopFilter),
		.result(result),
		.resultValid(resultValid),
		.filterActive(filterActive)
	);

	// The scoreboard only sees the top-level ports of the DUT.
	firChecker #(
		.tapCount(tapCount)
	) scoreboard (
		.clock(clock),
		.rstN(rstN),
		.coefWrite(coefWrite),
		.coefIndex(coefIndex),
		.coefData(coefData),
		.loadCoefficients(loadCoefficients),
		.sampleValid(sampleValid),
		.sampleIn(sampleIn),
		.stopFilter(stopFilter),
		.result(result),
		.resultValid(resultValid),
		.filterActive(filterActive),
		.errorCount(checkerErrors),
		.mismatchCount(mismatchCount)
	);

	// 10 ns clock.
	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Random component in the full signed range.
	// About one draw in eight hits one of the two extremes.
	function automatic int randomComponent();
		int r;
		r = $random(seed);
		case (r & 15)
			0: return -128;
			1: return 127;
			default: return int'(sample_t'(r >>> 8));
		endcase
	endfunction

	task automatic appendStep(input stepOp_t op, input int index, input int value);
		step_t s;
		s.op = op;
		s.index = tapIndex_t'(index);
		s.value = 16'(value);
		stimulus.push_back(s);
	endtask

	task automatic queueSample(input int re, input int im);
		appendStep(opSample, 0, int'({sample_t'(re), sample_t'(im)}));
	endtask

	task automatic writeCoefficient(input int index, input int re, input int im);
		appendStep(opWrite, index, int'({coef_t'(re), coef_t'(im)}));
	endtask

	// Fills the stimulus table, one section per behavior.
	task automatic buildStimulus();
		int k;
		// Samples before any load must be dropped.
		queueSample(5, -3);
		queueSample(-128, 127);
		appendStep(opIdle, 0, 0);
		// Known coefficients, real k+1 and imaginary -(2k+1). Index 14 has no entry.
		for (k = 0; k < tapCount; k++) begin
			writeCoefficient(k, k + 1, -(2 * k + 1));
		end
		writeCoefficient(14, 100, 100);
		appendStep(opLoad, 0, 0);
		appendStep(opWaitActive, 0, 1);
		// Real impulse, then an imaginary one, each flushed with zeros.
		queueSample(1, 0);
		for (k = 0; k < tapCount; k++) begin
			queueSample(0, 0);
		end
		queueSample(0, 1);
		for (k = 0; k < tapCount; k++) begin
			queueSample(0, 0);
		end
		// Corner values, then random samples with gaps.
		queueSample(-128, -128);
		queueSample(127, 127);
		queueSample(-128, 127);
		queueSample(127, -128);
		for (k = 0; k < 40; k++) begin
			if (($random(seed) & 3) == 0) begin
				appendStep(opIdle, 0, 0);
			end else begin
				queueSample(randomComponent(), randomComponent());
			end
		end
		// New coefficients and a load pulse while filtering only touch the bank.
		for (k = 0; k < tapCount; k++) begin
			writeCoefficient(k, randomComponent(), randomComponent());
		end
		writeCoefficient(tapCount - 1, -128, 127);
		appendStep(opLoad, 0, 0);
		for (k = 0; k < 16; k++) begin
			queueSample(randomComponent(), randomComponent());
		end
		// Stop, then samples that must be dropped until the reload finishes.
		appendStep(opStop, 0, 0);
		queueSample(randomComponent(), randomComponent());
		queueSample(randomComponent(), randomComponent());
		appendStep(opWaitActive, 0, 0);
		queueSample(randomComponent(), randomComponent());
		appendStep(opLoad, 0, 0);
		for (k = 0; k < 4; k++) begin
			queueSample(randomComponent(), randomComponent());
		end
		appendStep(opWaitActive, 0, 1);
		for (k = 0; k < 20; k++) begin
			if (($random(seed) & 3) == 0) begin
				appendStep(opIdle, 0, 0);
			end else begin
				queueSample(randomComponent(), randomComponent());
			end
		end
		// Room for the last result to come out.
		appendStep(opIdle, 0, 0);
		appendStep(opIdle, 0, 0);
	endtask

	task automatic clearStrobes();
		coefWrite = 1'b0;
		loadCoefficients = 1'b0;
		sampleValid = 1'b0;
		stopFilter = 1'b0;
	endtask

	// Polls filterActive once per cycle until it reaches the wanted level.
	task automatic waitForActive(input logic level);
		int cycles;
		cycles = 0;
		while ((filterActive !== level) && (cycles < waitLimit)) begin
			@(posedge clock);
			#1;
			cycles++;
		end
		if (filterActive !== level) begin
			timeoutCount++;
			$display("ERROR at time %0t: filterActive did not go to %0b within %0d cycles",
				$time, level, waitLimit);
		end
	endtask

	// Drives one row for one cycle, starting 1 ns after a rising edge.
	task automatic driveStep(input step_t s);
		clearStrobes();
		case (s.op)
			opWrite: begin
				coefWrite = 1'b1;
				coefIndex = s.index;
				coefData = complexCoef_t'(s.value);
			end
			opLoad: loadCoefficients = 1'b1;
			opSample: begin
				sampleValid = 1'b1;
				sampleIn = complexSample_t'(s.value);
			end
			opStop: stopFilter = 1'b1;
			default: ;
		endcase
		if (s.op == opWaitActive) begin
			waitForActive(s.value[0]);
		end else begin
			@(posedge clock);
			#1;
		end
	endtask

	initial begin
		seed = 32'h838e_a897;
		timeoutCount = 0;
		rstN = 1'b0;
		coefIndex = '0;
		coefData = '0;
		sampleIn = '0;
		clearStrobes();
		buildStimulus();
		repeat (3) @(posedge clock);
		#1;
		rstN = 1'b1;
		foreach (stimulus[i]) begin
			driveStep(stimulus[i]);
		end
		clearStrobes();
		$display("Run complete: %0d errors, %0d mismatches",
			timeoutCount + checkerErrors, mismatchCount);
		if ((timeoutCount + checkerErrors + mismatchCount) == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: sources.f
design/complexFirPkg.sv
design/coefficientBank.sv
design/complexFirCore.sv
design/complexFirTop.sv
tb/firChecker.sv
tb/complexFir_asserts.sv
tb/complexFirTb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module complexFirTb -f sources.f &&
./obj_dir/VcomplexFirTb 2>&1 | tee /dev/stderr | grep -qx "STATUS: PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
